//--- hw/dsi_pkg.sv
`default_nettype none

package dsi_pkg;

    typedef logic [31:0] word_t;       // pixel word, output FIFO word, PHY word
    typedef logic [5:0]  data_id_t;
    typedef logic [15:0] word_count_t; // long packet payload bytes
    typedef logic [7:0]  ecc_t;
    typedef logic [15:0] crc_t;
    typedef logic [2:0]  lane_count_t; // 1 to 4
    typedef logic [3:0]  lane_mask_t;

    localparam data_id_t DT_VSS   = 6'h01;
    localparam data_id_t DT_HSS   = 6'h21;
    localparam data_id_t DT_PPS24 = 6'h3E;

    // packet request from the sequencer
    typedef struct packed {
        data_id_t    data_id;
        word_count_t word_count;
        logic        long_pkt;
    } pkt_cmd_t;

    // one queued word toward the lanes
    typedef struct packed {
        logic  half; // only bytes 0 and 1 valid
        word_t data;
    } fifo_entry_t;

endpackage

`default_nettype wire

//--- hw/video_timing_pkg.sv
`default_nettype none

package video_timing_pkg;

    localparam int LINE_BYTES = 8;                // BYTES_PER_LINE
    localparam int LINE_WORDS = LINE_BYTES / 4;

    localparam int VSA_LINES = 1;
    localparam int VBP_LINES = 1;
    localparam int ACT_LINES = 2;
    localparam int VFP_LINES = 1;

    localparam int BLANK_CYCLES = 12; // after a sync packet
    localparam int HBP_CYCLES   = 4;  // before the payload on active lines

    localparam int LINE_COUNT_W = 8;
    localparam int BLANK_W      = $clog2(BLANK_CYCLES);
    localparam int WORD_CNT_W   = $clog2(LINE_WORDS + 1);

    typedef logic [LINE_COUNT_W-1:0] line_count_t;
    typedef logic [BLANK_W-1:0]      blank_count_t;
    typedef logic [WORD_CNT_W-1:0]   word_cnt_t;

    // reload values, the wait state lasts until the counter hits zero
    localparam blank_count_t BLANK_LOAD = blank_count_t'(BLANK_CYCLES - 1);
    localparam blank_count_t HBP_LOAD   = blank_count_t'(HBP_CYCLES - 1);

endpackage

`default_nettype wire

//--- hw/dsi_frame_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module dsi_frame_sequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              enable,
    input  logic              fifo_line_ready,
    output dsi_pkg::pkt_cmd_t cmd,
    output logic              cmd_valid,
    input  logic              cmd_done
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_VSS,
        ST_VSS_WAIT,
        ST_HSS_VSA,
        ST_WAIT_VSA,
        ST_HSS_VBP,
        ST_WAIT_VBP,
        ST_HSS_ACT,
        ST_WAIT_HBP,
        ST_PAYLOAD,
        ST_WAIT_HFP,
        ST_HSS_VFP,
        ST_WAIT_VFP
    } state_t;

    state_t                         state;
    state_t                         state_next;
    video_timing_pkg::blank_count_t blank_cnt;
    video_timing_pkg::line_count_t  line_cnt;
    logic                           blank_done;
    logic                           last_line;

    assign blank_done = (blank_cnt == '0);
    assign last_line  = (line_cnt == video_timing_pkg::line_count_t'(1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:     if (enable && fifo_line_ready) state_next = ST_VSS;
            ST_VSS:      if (cmd_done) state_next = ST_VSS_WAIT;
            ST_VSS_WAIT: if (blank_done) state_next = ST_HSS_VSA;
            ST_HSS_VSA:  if (cmd_done) state_next = ST_WAIT_VSA;
            ST_WAIT_VSA: if (blank_done) state_next = last_line ? ST_HSS_VBP : ST_HSS_VSA;
            ST_HSS_VBP:  if (cmd_done) state_next = ST_WAIT_VBP;
            ST_WAIT_VBP: if (blank_done) state_next = last_line ? ST_HSS_ACT : ST_HSS_VBP;
            ST_HSS_ACT:  if (cmd_done) state_next = ST_WAIT_HBP;
            ST_WAIT_HBP: if (blank_done) state_next = ST_PAYLOAD;
            ST_PAYLOAD:  if (cmd_done) state_next = ST_WAIT_HFP;
            ST_WAIT_HFP: if (blank_done) state_next = last_line ? ST_HSS_VFP : ST_HSS_ACT;
            ST_HSS_VFP:  if (cmd_done) state_next = ST_WAIT_VFP;
            ST_WAIT_VFP: if (blank_done) state_next = last_line ? ST_IDLE : ST_HSS_VFP;
            default:     state_next = ST_IDLE;
        endcase
    end

    // blanking starts counting only once the packet is queued
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            blank_cnt <= '0;
        else if (cmd_done)
            blank_cnt <= (state == ST_HSS_ACT) ? video_timing_pkg::HBP_LOAD
                                               : video_timing_pkg::BLANK_LOAD;
        else if (!blank_done)
            blank_cnt <= blank_cnt - 1'b1;
    end

    // lines left in the current vertical region
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            line_cnt <= '0;
        else if (blank_done)
        begin
            case (state)
                ST_VSS_WAIT:
                    line_cnt <= video_timing_pkg::line_count_t'(video_timing_pkg::VSA_LINES);
                ST_WAIT_VSA:
                    line_cnt <= last_line ?
                        video_timing_pkg::line_count_t'(video_timing_pkg::VBP_LINES) :
                        line_cnt - 1'b1;
                ST_WAIT_VBP:
                    line_cnt <= last_line ?
                        video_timing_pkg::line_count_t'(video_timing_pkg::ACT_LINES) :
                        line_cnt - 1'b1;
                ST_WAIT_HFP:
                    line_cnt <= last_line ?
                        video_timing_pkg::line_count_t'(video_timing_pkg::VFP_LINES) :
                        line_cnt - 1'b1;
                ST_WAIT_VFP:
                    line_cnt <= line_cnt - 1'b1;
                default:
                    line_cnt <= line_cnt;
            endcase
        end
    end

    assign cmd_valid = (state == ST_VSS)     || (state == ST_HSS_VSA) ||
                       (state == ST_HSS_VBP) || (state == ST_HSS_ACT) ||
                       (state == ST_PAYLOAD) || (state == ST_HSS_VFP);

    always_comb
    begin
        cmd.data_id    = dsi_pkg::DT_HSS;
        cmd.word_count = '0; // short packets carry zero data
        cmd.long_pkt   = 1'b0;
        if (state == ST_VSS)
            cmd.data_id = dsi_pkg::DT_VSS;
        else if (state == ST_PAYLOAD)
        begin
            cmd.data_id    = dsi_pkg::DT_PPS24;
            cmd.word_count = dsi_pkg::word_count_t'(video_timing_pkg::LINE_BYTES);
            cmd.long_pkt   = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/dsi_packet_builder.sv
`timescale 1ns/100ps
`default_nettype none

module dsi_packet_builder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dsi_pkg::pkt_cmd_t    cmd,
    input  logic                 cmd_valid,
    output logic                 cmd_done,
    input  dsi_pkg::word_t       fifo_data,
    input  logic                 fifo_not_empty,
    output logic                 fifo_read_ack,
    output dsi_pkg::fifo_entry_t entry,
    output logic                 fifo_empty,
    input  logic                 entry_pop
);

    typedef enum logic [1:0] {
        PH_HDR,
        PH_DATA,
        PH_CRC
    } phase_t;

    phase_t                      phase;
    video_timing_pkg::word_cnt_t words_left;
    dsi_pkg::crc_t               crc;
    logic [23:0]                 hdr_bits;
    dsi_pkg::word_t              header_word;
    logic                        fifo_full;
    logic                        hdr_write;
    logic                        crc_write;
    logic                        push;
    dsi_pkg::fifo_entry_t        push_entry;
    dsi_pkg::fifo_entry_t        mem [4];
    logic [1:0]                  wr_ptr;
    logic [1:0]                  rd_ptr;
    logic [2:0]                  count;

    // DSI header Hamming code, one parity bit per mask
    function automatic dsi_pkg::ecc_t ecc_calc(input logic [23:0] d);
        dsi_pkg::ecc_t e;
        e[0]   = ^(d & 24'hF12CB7);
        e[1]   = ^(d & 24'hF2555B);
        e[2]   = ^(d & 24'h749A6D);
        e[3]   = ^(d & 24'hB8E38E);
        e[4]   = ^(d & 24'hDF03F0);
        e[5]   = ^(d & 24'hEFFC00);
        e[7:6] = 2'b00;
        return e;
    endfunction

    // CRC-16 CCITT reflected, bytes LSB first
    function automatic dsi_pkg::crc_t crc_next(input dsi_pkg::crc_t c_in, input dsi_pkg::word_t d);
        dsi_pkg::crc_t c;
        c = c_in;
        for (int i = 0; i < 32; i++)
        begin
            if (c[0] ^ d[i])
                c = (c >> 1) ^ 16'h8408;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    assign hdr_bits    = {cmd.word_count, 2'b00, cmd.data_id}; // virtual channel 0
    assign header_word = {ecc_calc(hdr_bits), hdr_bits};

    assign hdr_write     = cmd_valid && (phase == PH_HDR) && !fifo_full;
    assign crc_write     = cmd_valid && (phase == PH_CRC) && !fifo_full;
    assign fifo_read_ack = cmd_valid && (phase == PH_DATA) && fifo_not_empty && !fifo_full;
    assign cmd_done      = (hdr_write && !cmd.long_pkt) || crc_write;
    assign push          = hdr_write || crc_write || fifo_read_ack;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase      <= PH_HDR;
            words_left <= '0;
        end
        else
        begin
            case (phase)
                PH_HDR:
                    if (hdr_write && cmd.long_pkt)
                    begin
                        phase      <= PH_DATA;
                        words_left <= video_timing_pkg::word_cnt_t'(video_timing_pkg::LINE_WORDS);
                    end
                PH_DATA:
                    if (fifo_read_ack)
                    begin
                        words_left <= words_left - 1'b1;
                        if (words_left == video_timing_pkg::word_cnt_t'(1))
                            phase <= PH_CRC;
                    end
                PH_CRC:
                    if (crc_write)
                        phase <= PH_HDR;
                default:
                    phase <= PH_HDR;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (hdr_write)
            crc <= 16'hFFFF; // seed per packet
        else if (fifo_read_ack)
            crc <= crc_next(crc, fifo_data);
    end

    always_comb
    begin
        push_entry.half = 1'b0;
        push_entry.data = header_word;
        if (phase == PH_DATA)
            push_entry.data = fifo_data;
        else if (phase == PH_CRC)
        begin
            push_entry.half = 1'b1;
            push_entry.data = {16'h0000, crc};
        end
    end

    // four-entry show-ahead output FIFO
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_entry;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (entry_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + {2'b00, push} - {2'b00, entry_pop};
        end
    end

    assign fifo_full  = (count == 3'd4);
    assign fifo_empty = (count == 3'd0);
    assign entry      = mem[rd_ptr];

endmodule

`default_nettype wire

//--- hw/dsi_lane_packer.sv
`timescale 1ns/100ps
`default_nettype none

module dsi_lane_packer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dsi_pkg::fifo_entry_t entry,
    input  logic                 fifo_empty,
    output logic                 entry_pop,
    input  dsi_pkg::lane_count_t lanes_number,
    input  dsi_pkg::lane_mask_t  phy_full,
    output dsi_pkg::word_t       phy_data,
    output dsi_pkg::lane_mask_t  phy_write
);

    logic [63:0] shift_reg;  // byte 0 is the oldest
    logic [3:0]  byte_cnt;
    logic [3:0]  lanes;
    logic [3:0]  out_n;
    logic [3:0]  in_n;
    logic [3:0]  kept;
    logic        write_en;
    logic [7:0]  strobe_wide;

    assign lanes    = {1'b0, lanes_number};
    // full lane group, or drain the tail when nothing else is queued
    assign write_en = !(|phy_full) &&
                      ((byte_cnt >= lanes) || ((byte_cnt != 4'd0) && fifo_empty));
    assign out_n    = !write_en ? 4'd0 :
                      (byte_cnt >= lanes) ? lanes : byte_cnt;
    assign kept     = byte_cnt - out_n;
    assign in_n     = entry.half ? 4'd2 : 4'd4;

    assign entry_pop = !fifo_empty && (kept <= 4'd4); // room for a whole word

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            shift_reg <= '0;
        else
            shift_reg <= (shift_reg >> {out_n, 3'b000}) |
                         ({64{entry_pop}} & ({32'h0, entry.data} << {kept, 3'b000}));
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            byte_cnt <= '0;
        else
            byte_cnt <= kept + (entry_pop ? in_n : 4'd0);
    end

    assign strobe_wide = (8'h01 << out_n) - 8'h01;
    assign phy_write   = strobe_wide[3:0];
    assign phy_data    = shift_reg[31:0];

endmodule

`default_nettype wire

//--- hw/dsi_tx_top.sv
`timescale 1ns/100ps
`default_nettype none

module dsi_tx_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enable,
    input  logic                 fifo_line_ready,
    input  logic                 fifo_not_empty,
    input  dsi_pkg::word_t       fifo_data,
    output logic                 fifo_read_ack,
    input  dsi_pkg::lane_count_t lanes_number,
    input  dsi_pkg::lane_mask_t  phy_full,
    output dsi_pkg::word_t       phy_data,
    output dsi_pkg::lane_mask_t  phy_write
);

    dsi_pkg::pkt_cmd_t    cmd;
    logic                 cmd_valid;
    logic                 cmd_done;
    dsi_pkg::fifo_entry_t entry;
    logic                 fifo_empty;
    logic                 entry_pop;

    dsi_frame_sequencer sequencer_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .enable          (enable),
        .fifo_line_ready (fifo_line_ready),
        .cmd             (cmd),
        .cmd_valid       (cmd_valid),
        .cmd_done        (cmd_done)
    );

    dsi_packet_builder builder_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd            (cmd),
        .cmd_valid      (cmd_valid),
        .cmd_done       (cmd_done),
        .fifo_data      (fifo_data),
        .fifo_not_empty (fifo_not_empty),
        .fifo_read_ack  (fifo_read_ack),
        .entry          (entry),
        .fifo_empty     (fifo_empty),
        .entry_pop      (entry_pop)
    );

    dsi_lane_packer packer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .entry        (entry),
        .fifo_empty   (fifo_empty),
        .entry_pop    (entry_pop),
        .lanes_number (lanes_number),
        .phy_full     (phy_full),
        .phy_data     (phy_data),
        .phy_write    (phy_write)
    );

endmodule

`default_nettype wire

//--- verif/dsi_tx_properties.sv
`timescale 1ns/100ps
`default_nettype none

module dsi_tx_properties (
    input logic                 clk,
    input logic                 rst_n,
    input dsi_pkg::lane_count_t lanes_number,
    input dsi_pkg::lane_mask_t  phy_full,
    input dsi_pkg::lane_mask_t  phy_write,
    input logic                 fifo_read_ack,
    input logic                 fifo_not_empty
);

    int fail_count = 0;

    // strobes fill from lane 0 up within the lane setting
    write_mask_a: assert property (@(posedge clk) disable iff (!rst_n)
        (phy_write inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111}) &&
        ($countones(phy_write) <= lanes_number))
    else
    begin
        $error("phy_write 0x%h not a lane 0 mask within %0d lanes", phy_write, lanes_number);
        fail_count++;
    end

    full_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        (phy_full != '0) |-> (phy_write == '0))
    else
    begin
        $error("phy_write 0x%h while phy_full 0x%h", phy_write, phy_full);
        fail_count++;
    end

    ack_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_read_ack |-> fifo_not_empty)
    else
    begin
        $error("fifo_read_ack with the pixel FIFO empty");
        fail_count++;
    end

endmodule

bind dsi_tx_top dsi_tx_properties props_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .lanes_number   (lanes_number),
    .phy_full       (phy_full),
    .phy_write      (phy_write),
    .fifo_read_ack  (fifo_read_ack),
    .fifo_not_empty (fifo_not_empty)
);

`default_nettype wire

//--- verif/dsi_tx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dsi_tx_tb;

    localparam int NUM_TESTS    = 5;
    localparam int PIX_WORDS    = video_timing_pkg::ACT_LINES * video_timing_pkg::LINE_WORDS;
    localparam int REC_WORDS    = 5 + PIX_WORDS + video_timing_pkg::ACT_LINES;
    localparam int FRAME_LIMIT  = 3000; // cycles per frame
    localparam int QUIET_CYCLES = 40;

    logic                 clk;
    logic                 rst_n;
    logic                 enable;
    logic                 fifo_line_ready;
    logic                 fifo_not_empty;
    dsi_pkg::word_t       fifo_data;
    logic                 fifo_read_ack;
    dsi_pkg::lane_count_t lanes_number;
    dsi_pkg::lane_mask_t  phy_full;
    dsi_pkg::word_t       phy_data;
    dsi_pkg::lane_mask_t  phy_write;

    dsi_pkg::word_t stim [NUM_TESTS*REC_WORDS];
    dsi_pkg::word_t pix_q [$];  // model pixel FIFO
    logic [7:0]     got_q [$];
    logic [7:0]     exp_q [$];
    int             ack_count;
    logic           ack_pending;
    int             seed = 34854;
    int             stall_pct;
    int             errors;
    int             tests_failed;
    int             total_errors;

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    dsi_tx_top dsi_tx_top_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .enable          (enable),
        .fifo_line_ready (fifo_line_ready),
        .fifo_not_empty  (fifo_not_empty),
        .fifo_data       (fifo_data),
        .fifo_read_ack   (fifo_read_ack),
        .lanes_number    (lanes_number),
        .phy_full        (phy_full),
        .phy_data        (phy_data),
        .phy_write       (phy_write)
    );

    // byte collector, lane 0 first
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (fifo_read_ack)
            begin
                ack_count++;
                ack_pending = 1'b1;
            end
            for (int i = 0; i < 4; i++)
            begin
                if (phy_write[i])
                    got_q.push_back(phy_data[8*i +: 8]);
            end
        end
    end

    task automatic step_cycle();
        int unsigned r;
        @(negedge clk);
        if (ack_pending && (pix_q.size() != 0))
            void'(pix_q.pop_front()); // read-ahead, next word shows now
        ack_pending     = 1'b0;
        fifo_not_empty  = (pix_q.size() != 0);
        fifo_data       = (pix_q.size() != 0) ? pix_q[0] : '0;
        fifo_line_ready = (pix_q.size() >= video_timing_pkg::LINE_WORDS);
        r = $random(seed);
        if ((stall_pct != 0) && ((r % 100) < stall_pct))
            phy_full = dsi_pkg::lane_mask_t'(4'b0001 << r[9:8]);
        else
            phy_full = '0;
    endtask

    task automatic push_bytes(input dsi_pkg::word_t w, input int n);
        for (int i = 0; i < n; i++)
            exp_q.push_back(w[8*i +: 8]);
    endtask

    task automatic build_expected(input int base);
        dsi_pkg::word_t vss_hdr;
        dsi_pkg::word_t hss_hdr;
        dsi_pkg::word_t pps_hdr;
        dsi_pkg::word_t crc_word;
        vss_hdr = stim[base + 2 + PIX_WORDS];
        hss_hdr = stim[base + 3 + PIX_WORDS];
        pps_hdr = stim[base + 4 + PIX_WORDS];
        exp_q.delete();
        push_bytes(vss_hdr, 4);
        for (int i = 0; i < video_timing_pkg::VSA_LINES + video_timing_pkg::VBP_LINES; i++)
            push_bytes(hss_hdr, 4);
        for (int ln = 0; ln < video_timing_pkg::ACT_LINES; ln++)
        begin
            push_bytes(hss_hdr, 4);
            push_bytes(pps_hdr, 4);
            for (int w = 0; w < video_timing_pkg::LINE_WORDS; w++)
                push_bytes(stim[base + 2 + ln*video_timing_pkg::LINE_WORDS + w], 4);
            crc_word = {16'h0000, stim[base + 5 + PIX_WORDS + ln][15:0]};
            push_bytes(crc_word, 2); // low byte first
        end
        for (int i = 0; i < video_timing_pkg::VFP_LINES; i++)
            push_bytes(hss_hdr, 4);
    endtask

    task automatic check_idle();
        int err_start;
        err_start = errors;
        got_q.delete();
        ack_count = 0;
        enable = 1'b1; // no line waiting yet
        for (int c = 0; c < QUIET_CYCLES; c++)
            step_cycle();
        enable = 1'b0;
        for (int w = 0; w < PIX_WORDS; w++)
            pix_q.push_back(stim[2 + w]);
        for (int c = 0; c < QUIET_CYCLES; c++)
            step_cycle();
        pix_q.delete();
        assert (got_q.size() == 0)
        else
        begin
            $display("ERR phy_write bytes while idle got 0x%0h exp 0x0", got_q.size());
            errors++;
        end
        assert (ack_count == 0)
        else
        begin
            $display("ERR fifo_read_ack count while idle got 0x%0h exp 0x0", ack_count);
            errors++;
        end
        if (errors != err_start)
            tests_failed++;
        $display("test idle: %s", (errors == err_start) ? "pass" : "FAIL");
    endtask

    task automatic run_frame(input int t);
        int base;
        int cycles;
        int err_start;
        int prop_start;
        int test_err;
        base       = t * REC_WORDS;
        err_start  = errors;
        prop_start = dsi_tx_top_i.props_i.fail_count;
        lanes_number = dsi_pkg::lane_count_t'(stim[base]);
        stall_pct    = int'(stim[base + 1]);
        pix_q.delete();
        for (int w = 0; w < PIX_WORDS; w++)
            pix_q.push_back(stim[base + 2 + w]);
        build_expected(base);
        got_q.delete();
        ack_count = 0;
        enable    = 1'b1;
        cycles    = 0;
        while ((got_q.size() < exp_q.size()) && (cycles < FRAME_LIMIT))
        begin
            step_cycle();
            cycles++;
        end
        enable = 1'b0;
        assert (got_q.size() >= exp_q.size())
        else
        begin
            $display("test %0d: frame did not complete within %0d cycles", t, FRAME_LIMIT);
            errors++;
        end
        for (int c = 0; c < QUIET_CYCLES; c++)
            step_cycle(); // let the sequencer go back to idle
        stall_pct = 0;
        assert (got_q.size() == exp_q.size())
        else
        begin
            $display("ERR phy_write byte count got 0x%0h exp 0x%0h", got_q.size(), exp_q.size());
            errors++;
        end
        for (int i = 0; (i < exp_q.size()) && (i < got_q.size()); i++)
        begin
            assert (got_q[i] == exp_q[i])
            else
            begin
                $display("ERR phy_data byte %0d got 0x%02h exp 0x%02h", i, got_q[i], exp_q[i]);
                errors++;
            end
        end
        assert (ack_count == PIX_WORDS)
        else
        begin
            $display("ERR fifo_read_ack count got 0x%0h exp 0x%0h", ack_count, PIX_WORDS);
            errors++;
        end
        test_err = (errors - err_start) + (dsi_tx_top_i.props_i.fail_count - prop_start);
        if (test_err != 0)
            tests_failed++;
        $display("test %0d lanes %0d stall %0d: %s", t, lanes_number, int'(stim[base + 1]),
                 (test_err == 0) ? "pass" : "FAIL");
    endtask

    initial
    begin
        rst_n           = 1'b0;
        enable          = 1'b0;
        fifo_line_ready = 1'b0;
        fifo_not_empty  = 1'b0;
        fifo_data       = '0;
        lanes_number    = dsi_pkg::lane_count_t'(4);
        phy_full        = '0;
        stall_pct       = 0;
        errors          = 0;
        tests_failed    = 0;
        ack_count       = 0;
        ack_pending     = 1'b0;
        $readmemh("verif/dsi_tx_stim.txt", stim);
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        assert (!$isunknown(stim[NUM_TESTS*REC_WORDS - 1]))
        else
        begin
            $display("stim file verif/dsi_tx_stim.txt is missing or too short");
            errors++;
            tests_failed++;
        end
        if (errors == 0)
        begin
            check_idle();
            for (int t = 0; t < NUM_TESTS; t++)
                run_frame(t);
        end
        total_errors = errors + dsi_tx_top_i.props_i.fail_count;
        $display("tests run %0d, failed %0d, errors %0d", NUM_TESTS + 1, tests_failed,
                 total_errors);
        if ((tests_failed == 0) && (total_errors == 0))
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hw/dsi_pkg.sv
hw/video_timing_pkg.sv
hw/dsi_frame_sequencer.sv
hw/dsi_packet_builder.sv
hw/dsi_lane_packer.sv
hw/dsi_tx_top.sv
verif/dsi_tx_properties.sv
verif/dsi_tx_tb.sv

//--- verif/dsi_tx_stim.txt
// per test: lanes stall_percent / pixel words of both active lines / VSS HSS PPS24 header words
// then one CRC per active line, all values hex
4 0
C4087FFF E60C8204 C204BFFF E102A408
07000001 12000021 2B00083E
2102 C60C
1 0
C204BFFF E102A408 E60C3FFF C2046102
07000001 12000021 2B00083E
C60C 8408
2 0
E60C3FFF C2046102 C4087FFF E60C8204
07000001 12000021 2B00083E
8408 2102
3 28
C4087FFF E60C8204 E60C3FFF C2046102
07000001 12000021 2B00083E
2102 8408
4 19
C204BFFF E102A408 C4087FFF E60C8204
07000001 12000021 2B00083E
C60C 2102
